//--- Makefile
TOP := tb_exec_cluster

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- list.f
rtl/exec_pkg.sv
rtl/result_fifo.sv
rtl/alu_unit.sv
rtl/mdu_unit.sv
rtl/cdb_arbiter.sv
rtl/exec_cluster.sv
tb/tb_exec_cluster.sv

//--- rtl/alu_unit.sv
`default_nettype none

module alu_unit
    import exec_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire            flush_i,
    input  wire            req_valid_i,
    input  wire alu_req_t  req_i,
    output logic           req_ready_o,
    output logic           res_valid_o,
    output cdb_info_t      res_o,
    input  wire            res_ready_i
);

    word_t      result;
    logic [4:0] shamt;
    cdb_info_t  res_pkt;

    assign shamt = req_i.src1[4:0];

    always_comb begin
        case (req_i.op)
            ADD:     result = req_i.src0 + req_i.src1;
            SUB:     result = req_i.src0 - req_i.src1;
            AND:     result = req_i.src0 & req_i.src1;
            OR:      result = req_i.src0 | req_i.src1;
            XOR:     result = req_i.src0 ^ req_i.src1;
            SLT:     result = {31'd0, $signed(req_i.src0) < $signed(req_i.src1)};
            SLTU:    result = {31'd0, req_i.src0 < req_i.src1};
            SLL:     result = req_i.src0 << shamt;
            SRL:     result = req_i.src0 >> shamt;
            SRA:     result = word_t'($signed(req_i.src0) >>> shamt);
            default: result = '0; // unused encodings
        endcase
    end

    always_comb begin
        res_pkt.tag   = req_i.tag;
        res_pkt.data  = result;
        res_pkt.fu_id = FU_ALU;
    end

    // result goes straight into the queue on the accepting edge
    result_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) res_fifo_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .in_valid_i (req_valid_i),
        .in_data_i  (res_pkt),
        .in_ready_o (req_ready_o),
        .out_valid_o(res_valid_o),
        .out_data_o (res_o),
        .out_ready_i(res_ready_i),
        .count_o    ()
    );

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter
    import exec_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n_i,
    input  wire             flush_i,
    input  wire             alu_valid_i,
    input  wire cdb_info_t  alu_res_i,
    output logic            alu_ready_o,
    input  wire             mdu_valid_i,
    input  wire cdb_info_t  mdu_res_i,
    output logic            mdu_ready_o,
    output logic            cdb_valid_o,
    output cdb_info_t       cdb_o
);

    logic      last_mdu;  // winner of the last contended cycle
    logic      contend;
    logic      gnt_alu;
    logic      gnt_mdu;
    logic      cdb_valid_q;
    cdb_info_t cdb_q;

    assign contend = alu_valid_i & mdu_valid_i;

    always_comb begin
        gnt_alu = alu_valid_i & (~mdu_valid_i | last_mdu);
        gnt_mdu = mdu_valid_i & (~alu_valid_i | ~last_mdu);
    end

    // grant doubles as the pop of the queue head
    assign alu_ready_o = gnt_alu;
    assign mdu_ready_o = gnt_mdu;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_mdu <= 1'b1; // alu first
        end else if (contend) begin
            last_mdu <= ~last_mdu; // a lone request leaves the order alone
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cdb_valid_q <= 1'b0;
        end else if (flush_i) begin
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= gnt_alu | gnt_mdu;
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_alu | gnt_mdu) begin
            cdb_q <= gnt_mdu ? mdu_res_i : alu_res_i;
        end
    end

    assign cdb_valid_o = cdb_valid_q;
    assign cdb_o       = cdb_q;

    assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({alu_ready_o, mdu_ready_o}))
        else $error("cdb_arbiter: both sources granted");

endmodule

`default_nettype wire

//--- rtl/exec_cluster.sv
`default_nettype none

module exec_cluster
    import exec_pkg::*;
#(
    parameter int ALU_FIFO_DEPTH = 4,
    parameter int MDU_FIFO_DEPTH = 4,
    parameter int MUL_STAGES     = 3
) (
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire            flush_i,
    input  wire            alu_req_valid_i,
    input  wire alu_req_t  alu_req_i,
    output logic           alu_req_ready_o,
    input  wire            mdu_req_valid_i,
    input  wire mdu_req_t  mdu_req_i,
    output logic           mdu_req_ready_o,
    output logic           cdb_valid_o,
    output cdb_info_t      cdb_o
);

    logic      alu_res_valid;
    cdb_info_t alu_res;
    logic      alu_res_ready;
    logic      mdu_res_valid;
    cdb_info_t mdu_res;
    logic      mdu_res_ready;

    alu_unit #(
        .FIFO_DEPTH(ALU_FIFO_DEPTH)
    ) alu_unit_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .req_valid_i(alu_req_valid_i),
        .req_i      (alu_req_i),
        .req_ready_o(alu_req_ready_o),
        .res_valid_o(alu_res_valid),
        .res_o      (alu_res),
        .res_ready_i(alu_res_ready)
    );

    mdu_unit #(
        .FIFO_DEPTH(MDU_FIFO_DEPTH),
        .MUL_STAGES(MUL_STAGES)
    ) mdu_unit_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .req_valid_i(mdu_req_valid_i),
        .req_i      (mdu_req_i),
        .req_ready_o(mdu_req_ready_o),
        .res_valid_o(mdu_res_valid),
        .res_o      (mdu_res),
        .res_ready_i(mdu_res_ready)
    );

    // single-lane broadcast, no back-pressure from the bus
    cdb_arbiter cdb_arbiter_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .alu_valid_i(alu_res_valid),
        .alu_res_i  (alu_res),
        .alu_ready_o(alu_res_ready),
        .mdu_valid_i(mdu_res_valid),
        .mdu_res_i  (mdu_res),
        .mdu_ready_o(mdu_res_ready),
        .cdb_valid_o(cdb_valid_o),
        .cdb_o      (cdb_o)
    );

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_tag_t; // physical destination register

    // integer ops, shifts take src1[4:0]
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL   = 2'd0, // low word
        MULH  = 2'd1, // high word, signed x signed
        MULHU = 2'd2  // high word, unsigned x unsigned
    } mdu_op_e;

    typedef struct packed {
        alu_op_e  op;
        word_t    src0;
        word_t    src1;
        rob_tag_t tag;
    } alu_req_t;

    typedef struct packed {
        mdu_op_e  op;
        word_t    src0;
        word_t    src1;
        rob_tag_t tag;
    } mdu_req_t;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MDU = 1'b1
    } fu_id_e;

    // one result broadcast
    typedef struct packed {
        rob_tag_t tag;
        word_t    data;
        fu_id_e   fu_id;
    } cdb_info_t;

endpackage

`default_nettype wire

//--- rtl/mdu_unit.sv
`default_nettype none

module mdu_unit
    import exec_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int MUL_STAGES = 3
) (
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire            flush_i,
    input  wire            req_valid_i,
    input  wire mdu_req_t  req_i,
    output logic           req_ready_o,
    output logic           res_valid_o,
    output cdb_info_t      res_o,
    input  wire            res_ready_i
);

    localparam int IFL_W  = $clog2(MUL_STAGES + 1);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRED_W = $clog2(FIFO_DEPTH + MUL_STAGES + 1);

    typedef struct packed {
        logic        hi;   // take upper word
        rob_tag_t    tag;
        logic [63:0] prod;
    } mul_pay_t;

    logic signed [63:0]    op_a;
    logic signed [63:0]    op_b;
    logic                  sext;
    mul_pay_t              in_pay;
    logic                  accept;
    logic [MUL_STAGES-1:0] stg_valid;
    mul_pay_t              stg_pay [MUL_STAGES];
    logic [IFL_W-1:0]      inflight;
    logic [CNT_W-1:0]      fifo_count;
    logic [CRED_W-1:0]     credit;
    logic                  fifo_in_ready;
    cdb_info_t             out_pkt;

    assign accept = req_valid_i & req_ready_o;

    // only MULH needs signed operands since the MUL low word is the same either way
    assign sext = (req_i.op == MULH);

    always_comb begin
        op_a        = {{32{sext & req_i.src0[31]}}, req_i.src0};
        op_b        = {{32{sext & req_i.src1[31]}}, req_i.src1};
        in_pay.hi   = (req_i.op != MUL);
        in_pay.tag  = req_i.tag;
        in_pay.prod = op_a * op_b;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stg_valid <= '0;
        end else if (flush_i) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= {stg_valid[MUL_STAGES-2:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        stg_pay[0] <= in_pay;
        for (int i = 1; i < MUL_STAGES; i++) begin
            stg_pay[i] <= stg_pay[i-1];
        end
    end

    // items still inside the multiplier
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inflight <= '0;
        end else if (flush_i) begin
            inflight <= '0;
        end else begin
            inflight <= inflight + IFL_W'(accept) - IFL_W'(stg_valid[MUL_STAGES-1]);
        end
    end

    // a slot is reserved in the queue before issue, so the pipe never stalls
    assign credit      = CRED_W'(fifo_count) + CRED_W'(inflight);
    assign req_ready_o = (credit < CRED_W'(FIFO_DEPTH));

    always_comb begin
        out_pkt.tag   = stg_pay[MUL_STAGES-1].tag;
        out_pkt.data  = stg_pay[MUL_STAGES-1].hi ? stg_pay[MUL_STAGES-1].prod[63:32]
                                                 : stg_pay[MUL_STAGES-1].prod[31:0];
        out_pkt.fu_id = FU_MDU;
    end

    // enters the queue MUL_STAGES edges after acceptance
    result_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) res_fifo_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .in_valid_i (stg_valid[MUL_STAGES-1]),
        .in_data_i  (out_pkt),
        .in_ready_o (fifo_in_ready),
        .out_valid_o(res_valid_o),
        .out_data_o (res_o),
        .out_ready_i(res_ready_i),
        .count_o    (fifo_count)
    );

    assert property (@(posedge clk) disable iff (!arst_n_i)
        credit <= CRED_W'(FIFO_DEPTH) && !(stg_valid[MUL_STAGES-1] && inflight == '0))
        else $error("mdu_unit: credit count out of range");

    // the reserved slot must really be free when the product lands
    assert property (@(posedge clk) disable iff (!arst_n_i)
        stg_valid[MUL_STAGES-1] |-> fifo_in_ready)
        else $error("mdu_unit: product dropped at full queue");

endmodule

`default_nettype wire

//--- rtl/result_fifo.sv
`default_nettype none

module result_fifo
    import exec_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           flush_i,
    input  wire                           in_valid_i,
    input  wire cdb_info_t                in_data_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output cdb_info_t                     out_data_o,
    input  wire                           out_ready_i,
    output logic [$clog2(DEPTH+1)-1:0]    count_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cdb_info_t        mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // a full buffer still takes an entry when the head leaves in the same cycle
    assign in_ready_o  = ~full | out_ready_i;
    assign out_valid_o = ~empty;
    assign out_data_o  = mem[rd_ptr];
    assign count_o     = count;

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin // drops everything, incl. this cycle's push
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data_i;
    end

    // consumer must only pull from a non-empty queue
    assert property (@(posedge clk) disable iff (!arst_n_i) out_ready_i |-> !empty)
        else $error("result_fifo: pop from empty buffer");

endmodule

`default_nettype wire

//--- tb/tb_exec_cluster.sv
`default_nettype none

module tb_exec_cluster
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int MUL_STAGES   = 3;  // DUT default
    localparam int RAND_CYCLES  = 400;
    localparam int CONT_CYCLES  = 120;
    localparam int DRAIN_CYCLES = 40;
    localparam int REQ_BUDGET   = 96 + 2 * (RAND_CYCLES + CONT_CYCLES + 90);
    localparam int WD_CYCLES    = REQ_BUDGET * 20;

    typedef struct packed {
        rob_tag_t    tag;
        word_t       data;
        logic [31:0] cyc;  // edge of acceptance
    } exp_t;

    logic      clk;
    logic      arst_n_i;
    logic      flush_i;
    logic      alu_req_valid_i;
    alu_req_t  alu_req_i;
    logic      alu_req_ready_o;
    logic      mdu_req_valid_i;
    mdu_req_t  mdu_req_i;
    logic      mdu_req_ready_o;
    logic      cdb_valid_o;
    cdb_info_t cdb_o;

    exp_t        alu_q[$];
    exp_t        mdu_q[$];
    logic        stale [64];  // tags wiped out by a flush
    logic [31:0] cyc;
    logic        alu_fire;
    logic        mdu_fire;
    logic        check_latency;
    logic        in_contention;
    logic        prev_contended;
    fu_id_e      prev_fu;
    logic [31:0] prev_obs;
    rob_tag_t    next_tag;
    int          errors;
    int          checks;
    int          alu_drops;
    int          mdu_drops;

    exec_cluster exec_cluster_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .alu_req_valid_i(alu_req_valid_i),
        .alu_req_i      (alu_req_i),
        .alu_req_ready_o(alu_req_ready_o),
        .mdu_req_valid_i(mdu_req_valid_i),
        .mdu_req_i      (mdu_req_i),
        .mdu_req_ready_o(mdu_req_ready_o),
        .cdb_valid_o    (cdb_valid_o),
        .cdb_o          (cdb_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t alu_model(alu_op_e opc, word_t a, word_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a};  // sign fill for arithmetic shift
        case (opc)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return word_t'(ext >> b[4:0]);
            default: return '0;
        endcase
    endfunction

    function automatic word_t mdu_model(mdu_op_e opc, word_t a, word_t b);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'd0, a} * {32'd0, b};
        case (opc)
            MUL:     return uprod[31:0];
            MULH:    return sprod[63:32];
            MULHU:   return uprod[63:32];
            default: return '0;
        endcase
    endfunction

    function automatic word_t corner_word(int sel);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    function automatic word_t pick_word();
        return corner_word(int'($urandom_range(5, 0)));
    endfunction

    task automatic check_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic record_accept(fu_id_e fu, rob_tag_t tag, word_t data);
        exp_t e;
        e.tag      = tag;
        e.data     = data;
        e.cyc      = cyc;
        stale[tag] = 1'b0;  // tag reissued
        if (fu == FU_ALU) alu_q.push_back(e);
        else mdu_q.push_back(e);
    endtask

    task automatic drop_outstanding();
        foreach (alu_q[i]) stale[alu_q[i].tag] = 1'b1;
        foreach (mdu_q[i]) stale[mdu_q[i].tag] = 1'b1;
        if (alu_req_valid_i) stale[alu_req_i.tag] = 1'b1;  // presented in the flush cycle
        if (mdu_req_valid_i) stale[mdu_req_i.tag] = 1'b1;
        alu_q.delete();
        mdu_q.delete();
        prev_contended = 1'b0;
    endtask

    task automatic check_result();
        exp_t head;
        logic found;
        logic other_ready;  // other head waited at the grant edge
        int   lat;
        int   exp_lat;
        checks++;
        found = 1'b0;
        if (stale[cdb_o.tag]) begin
            $display("cycle %0d: tag %h from before the flush reached the bus", cyc, cdb_o.tag);
            errors++;
        end
        if (cdb_o.fu_id == FU_ALU) begin
            other_ready = (mdu_q.size() > 0) && (mdu_q[0].cyc + MUL_STAGES <= cyc - 2);
            exp_lat     = 1;  // fifo write on accept, bus register next edge
            if (alu_q.size() > 0) begin
                head  = alu_q.pop_front();
                found = 1'b1;
            end
        end else begin
            other_ready = (alu_q.size() > 0) && (alu_q[0].cyc <= cyc - 2);
            exp_lat     = MUL_STAGES + 1;
            if (mdu_q.size() > 0) begin
                head  = mdu_q.pop_front();
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("cycle %0d: %s result with tag %h but nothing outstanding",
                     cyc, cdb_o.fu_id.name(), cdb_o.tag);
            errors++;
        end else begin
            lat = int'(cyc - head.cyc) - 1;
            if (cdb_o.tag !== head.tag) begin
                $display("Fail cdb_o.tag expected %h got %h", head.tag, cdb_o.tag);
                errors++;
            end
            if (cdb_o.data !== head.data) begin
                $display("Fail cdb_o.data expected %h got %h", head.data, cdb_o.data);
                errors++;
            end
            if (check_latency && lat != exp_lat) begin
                $display("cycle %0d: tag %h took %0d cycles instead of %0d",
                         cyc, head.tag, lat, exp_lat);
                errors++;
            end
        end
        if (prev_contended && other_ready && prev_obs == cyc - 1 && prev_fu == cdb_o.fu_id) begin
            $display("cycle %0d: %s won the bus twice in a row under contention",
                     cyc, cdb_o.fu_id.name());
            errors++;
        end
        prev_contended = other_ready;
        prev_fu        = cdb_o.fu_id;
        prev_obs       = cyc;
    endtask

    // everything sampled on the edge, before the DUT registers update
    always @(posedge clk) begin
        cyc      = cyc + 1;
        alu_fire = arst_n_i && !flush_i && alu_req_valid_i && alu_req_ready_o;
        mdu_fire = arst_n_i && !flush_i && mdu_req_valid_i && mdu_req_ready_o;
        if (arst_n_i && cdb_valid_o) check_result();
        if (alu_fire) begin
            record_accept(FU_ALU, alu_req_i.tag,
                          alu_model(alu_req_i.op, alu_req_i.src0, alu_req_i.src1));
        end
        if (mdu_fire) begin
            record_accept(FU_MDU, mdu_req_i.tag,
                          mdu_model(mdu_req_i.op, mdu_req_i.src0, mdu_req_i.src1));
        end
        if (arst_n_i && flush_i) drop_outstanding();
        if (in_contention && !alu_req_ready_o) alu_drops++;
        if (in_contention && !mdu_req_ready_o) mdu_drops++;
    end

    task automatic present_alu(alu_op_e opc, word_t a, word_t b);
        alu_req_i       = '{op: opc, src0: a, src1: b, tag: next_tag};
        alu_req_valid_i = 1'b1;
        next_tag        = next_tag + 6'd1;
    endtask

    task automatic present_mdu(mdu_op_e opc, word_t a, word_t b);
        mdu_req_i       = '{op: opc, src0: a, src1: b, tag: next_tag};
        mdu_req_valid_i = 1'b1;
        next_tag        = next_tag + 6'd1;
    endtask

    task automatic wait_idle();
        while (alu_q.size() > 0 || mdu_q.size() > 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_alu(alu_op_e opc, word_t a, word_t b);
        present_alu(opc, a, b);
        @(posedge clk);
        #1;
        while (!alu_fire) begin
            @(posedge clk);
            #1;
        end
        alu_req_valid_i = 1'b0;
        wait_idle();
    endtask

    task automatic send_mdu(mdu_op_e opc, word_t a, word_t b);
        present_mdu(opc, a, b);
        @(posedge clk);
        #1;
        while (!mdu_fire) begin
            @(posedge clk);
            #1;
        end
        mdu_req_valid_i = 1'b0;
        wait_idle();
    endtask

    // payload held until accepted, then a new one with some probability
    task automatic run_traffic(int cycles, int alu_pct, int mdu_pct);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (alu_fire) alu_req_valid_i = 1'b0;
            if (mdu_fire) mdu_req_valid_i = 1'b0;
            if (!alu_req_valid_i && $urandom_range(99, 0) < alu_pct) begin
                present_alu(alu_op_e'($urandom_range(9, 0)), pick_word(), pick_word());
            end
            if (!mdu_req_valid_i && $urandom_range(99, 0) < mdu_pct) begin
                present_mdu(mdu_op_e'($urandom_range(2, 0)), pick_word(), pick_word());
            end
        end
    endtask

    task automatic retire_requests();
        while (alu_req_valid_i || mdu_req_valid_i) begin
            @(posedge clk);
            #1;
            if (alu_fire) alu_req_valid_i = 1'b0;
            if (mdu_fire) mdu_req_valid_i = 1'b0;
        end
    endtask

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        arst_n_i        = 1'b0;
        flush_i         = 1'b0;
        alu_req_valid_i = 1'b0;
        alu_req_i       = '0;
        mdu_req_valid_i = 1'b0;
        mdu_req_i       = '0;
        cyc             = '0;
        check_latency   = 1'b0;
        in_contention   = 1'b0;
        prev_contended  = 1'b0;
        prev_fu         = FU_ALU;
        prev_obs        = '0;
        next_tag        = '0;
        errors          = 0;
        checks          = 0;
        alu_drops       = 0;
        mdu_drops       = 0;
        foreach (stale[i]) stale[i] = 1'b0;
        void'($urandom(32'hcebf));

        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check_bit("cdb_valid_o", 1'b0, cdb_valid_o);
        check_bit("alu_req_ready_o", 1'b1, alu_req_ready_o);
        check_bit("mdu_req_ready_o", 1'b1, mdu_req_ready_o);

        // lone requests on an idle cluster
        check_latency = 1'b1;
        for (int op = 0; op < 10; op++) begin
            send_alu(alu_op_e'(op), $urandom(), $urandom());
            send_alu(alu_op_e'(op), 32'h8000_0000, 32'h0000_0001);  // signed vs unsigned
            send_alu(alu_op_e'(op), 32'hf0f0_1234, 32'hffff_ffe0);  // shift by 0
            send_alu(alu_op_e'(op), 32'h8765_4321, 32'h0000_001f);  // shift by 31
        end
        for (int op = 0; op < 3; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_mdu(mdu_op_e'(op), corner_word(i), corner_word(j));
                end
            end
        end
        check_latency = 1'b0;

        run_traffic(RAND_CYCLES, 40, 30);
        retire_requests();
        wait_idle();

        // both channels busy every cycle
        in_contention = 1'b1;
        run_traffic(CONT_CYCLES, 100, 100);
        in_contention = 1'b0;
        retire_requests();
        wait_idle();
        if (alu_drops == 0) begin
            $display("alu_req_ready_o never dropped while both channels were busy");
            errors++;
        end
        if (mdu_drops == 0) begin
            $display("mdu_req_ready_o never dropped while both channels were busy");
            errors++;
        end

        run_traffic(30, 80, 80);
        flush_i = 1'b1;  // requests still presented are dropped
        @(posedge clk);
        #1;
        flush_i         = 1'b0;
        alu_req_valid_i = 1'b0;
        mdu_req_valid_i = 1'b0;
        check_bit("alu_req_ready_o", 1'b1, alu_req_ready_o);
        check_bit("mdu_req_ready_o", 1'b1, mdu_req_ready_o);
        repeat (12) begin
            check_bit("cdb_valid_o", 1'b0, cdb_valid_o);
            @(posedge clk);
            #1;
        end
        run_traffic(60, 50, 50);
        retire_requests();

        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        if (alu_q.size() != 0 || mdu_q.size() != 0) begin
            $display("%0d ALU and %0d MDU results never reached the bus",
                     alu_q.size(), mdu_q.size());
            errors++;
        end

        $display("results checked %0d, ready drops alu %0d mdu %0d, errors %0d",
                 checks, alu_drops, mdu_drops, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
